// ==== src/tmr_pkg.sv ====
// TMR accumulator shared types
`default_nettype none

package tmr_pkg;

  localparam int unsigned NumCores   = 3;
  localparam int unsigned DataWidth  = 16;
  localparam int unsigned NumCredits = 4;  // Queue depth and response credits
  localparam int unsigned CntWidth   = 8;

  localparam int unsigned PtrWidth  = $clog2(NumCredits);
  localparam int unsigned FillWidth = $clog2(NumCredits + 1);
  localparam int unsigned ShWidth   = $clog2(DataWidth);

  typedef enum logic [1:0] {
    OP_LOAD = 2'd0,
    OP_ADD  = 2'd1,
    OP_XOR  = 2'd2,
    OP_SHL  = 2'd3
  } op_e;

  typedef struct packed {
    op_e                  op;
    logic [DataWidth-1:0] operand;
  } cmd_t;

  // Replica state, the voted quantity
  typedef struct packed {
    logic                 valid;
    logic [DataWidth-1:0] acc;
    op_e                  op;
  } core_state_t;

  typedef struct packed {
    logic [DataWidth-1:0] acc;
    op_e                  op;
  } rsp_t;

endpackage

`default_nettype wire

// ==== src/cmd_ingress.sv ====
// Command queue with credit return
`timescale 1ns/1ps
`default_nettype none

module cmd_ingress (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          cmd_valid_i,
  input  tmr_pkg::cmd_t cmd_i,
  input  logic          issue_ok_i,
  output logic          cmd_credit_o,
  output logic          issue_o,
  output tmr_pkg::cmd_t issue_cmd_o
);

  tmr_pkg::cmd_t mem_q [tmr_pkg::NumCredits];

  logic [tmr_pkg::PtrWidth-1:0]  wr_ptr_q;
  logic [tmr_pkg::PtrWidth-1:0]  rd_ptr_q;
  logic [tmr_pkg::FillWidth-1:0] fill_q;
  logic                          push;
  logic                          pop;

  // Sender credits keep the queue from overflowing
  assign push = cmd_valid_i && (fill_q != tmr_pkg::FillWidth'(tmr_pkg::NumCredits));
  assign pop  = (fill_q != '0) && issue_ok_i;

  assign issue_o      = pop;
  assign issue_cmd_o  = mem_q[rd_ptr_q];
  assign cmd_credit_o = pop;  // One credit back per issued command

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/acc_core.sv ====
// Accumulator core replica
`timescale 1ns/1ps
`default_nettype none

module acc_core (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 issue_i,
  input  tmr_pkg::cmd_t        cmd_i,
  input  logic                 resync_i,
  input  tmr_pkg::core_state_t voted_i,
  input  logic                 fault_inj_i,
  output tmr_pkg::core_state_t state_o
);

  tmr_pkg::core_state_t state_q;
  tmr_pkg::core_state_t state_d;

  logic [tmr_pkg::DataWidth-1:0] base_acc;
  logic [tmr_pkg::DataWidth-1:0] result;
  tmr_pkg::op_e                  base_op;

  always_comb begin
    // Resync replaces the local state before the command is applied
    base_acc = resync_i ? voted_i.acc : state_q.acc;
    base_op  = resync_i ? voted_i.op : state_q.op;

    case (cmd_i.op)
      tmr_pkg::OP_LOAD: result = cmd_i.operand;
      tmr_pkg::OP_ADD:  result = base_acc + cmd_i.operand;
      tmr_pkg::OP_XOR:  result = base_acc ^ cmd_i.operand;
      tmr_pkg::OP_SHL:  result = base_acc << cmd_i.operand[tmr_pkg::ShWidth-1:0];
      default:          result = base_acc;
    endcase

    state_d.valid = issue_i;
    state_d.acc   = base_acc;
    state_d.op    = base_op;
    if (issue_i) begin
      state_d.acc = result;
      state_d.op  = cmd_i.op;
    end
    if (fault_inj_i) begin
      state_d.acc = base_acc ^ tmr_pkg::DataWidth'(1);  // Flip bit 0
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

// ==== src/tmr_voter.sv ====
// Bitwise majority voter
`timescale 1ns/1ps
`default_nettype none

module tmr_voter (
  input  tmr_pkg::core_state_t [tmr_pkg::NumCores-1:0] state_i,
  output tmr_pkg::core_state_t                         voted_o,
  output logic                 [tmr_pkg::NumCores-1:0] faulty_o,
  output logic                                         error_o,
  output logic                                         failure_o
);

  logic [$bits(tmr_pkg::core_state_t)-1:0] s0;
  logic [$bits(tmr_pkg::core_state_t)-1:0] s1;
  logic [$bits(tmr_pkg::core_state_t)-1:0] s2;

  assign s0 = state_i[0];
  assign s1 = state_i[1];
  assign s2 = state_i[2];

  // Two of three per bit
  assign voted_o = (s0 & s1) | (s0 & s2) | (s1 & s2);

  always_comb begin
    for (int i = 0; i < tmr_pkg::NumCores; i++) begin
      faulty_o[i] = (state_i[i] != voted_o);
    end
  end

  assign error_o = |faulty_o;

  // No pair agrees
  assign failure_o = (s0 != s1) && (s0 != s2) && (s1 != s2);

endmodule

`default_nettype wire

// ==== src/fault_monitor.sv ====
// Replica error counters and resync
`timescale 1ns/1ps
`default_nettype none

module fault_monitor (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic [tmr_pkg::NumCores-1:0]                 faulty_i,
  output logic [tmr_pkg::NumCores-1:0]                 resync_o,
  output logic [tmr_pkg::NumCores-1:0][tmr_pkg::CntWidth-1:0] err_cnt_o
);

  logic [tmr_pkg::NumCores-1:0][tmr_pkg::CntWidth-1:0] err_cnt_q;

  // Faulty replica loads the voted state at the edge closing its faulty cycle
  assign resync_o = faulty_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_cnt_q <= '0;
    end else begin
      for (int i = 0; i < tmr_pkg::NumCores; i++) begin
        if (faulty_i[i] && (err_cnt_q[i] != '1)) begin  // Saturate at all ones
          err_cnt_q[i] <= err_cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign err_cnt_o = err_cnt_q;

endmodule

`default_nettype wire

// ==== src/rsp_egress.sv ====
// Response credits and output register
`timescale 1ns/1ps
`default_nettype none

module rsp_egress (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 issue_i,
  input  tmr_pkg::core_state_t voted_i,
  input  logic                 rsp_credit_i,
  output logic                 issue_ok_o,
  output logic                 rsp_valid_o,
  output tmr_pkg::rsp_t        rsp_o
);

  logic [tmr_pkg::FillWidth-1:0] credit_q;
  logic                          rsp_valid_q;
  tmr_pkg::rsp_t                 rsp_q;

  assign issue_ok_o = (credit_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q    <= tmr_pkg::FillWidth'(tmr_pkg::NumCredits);
      rsp_valid_q <= 1'b0;
    end else begin
      credit_q    <= credit_q + tmr_pkg::FillWidth'(rsp_credit_i)
                     - tmr_pkg::FillWidth'(issue_i);
      rsp_valid_q <= voted_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (voted_i.valid) begin
      rsp_q <= '{acc: voted_i.acc, op: voted_i.op};
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// ==== src/tmr_core_wrap.sv ====
// TMR accumulator top level
`timescale 1ns/1ps
`default_nettype none

module tmr_core_wrap (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         cmd_valid_i,
  input  tmr_pkg::cmd_t                                cmd_i,
  output logic                                         cmd_credit_o,
  input  logic                                         rsp_credit_i,
  output logic                                         rsp_valid_o,
  output tmr_pkg::rsp_t                                rsp_o,
  input  logic [tmr_pkg::NumCores-1:0]                 fault_inj_i,
  output logic                                         tmr_error_o,
  output logic                                         tmr_failure_o,
  output logic [tmr_pkg::NumCores-1:0]                 faulty_o,
  output logic [tmr_pkg::NumCores-1:0][tmr_pkg::CntWidth-1:0] err_cnt_o
);

  logic                                         issue_ok;
  logic                                         issue;
  tmr_pkg::cmd_t                                issue_cmd;
  tmr_pkg::core_state_t [tmr_pkg::NumCores-1:0] core_state;
  tmr_pkg::core_state_t                         voted;
  logic [tmr_pkg::NumCores-1:0]                 resync;

  cmd_ingress u_ingress (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .issue_ok_i   (issue_ok),
    .cmd_credit_o (cmd_credit_o),
    .issue_o      (issue),
    .issue_cmd_o  (issue_cmd)
  );

  // Same command to every replica
  for (genvar i = 0; i < tmr_pkg::NumCores; i++) begin : gen_cores
    acc_core u_core (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .issue_i     (issue),
      .cmd_i       (issue_cmd),
      .resync_i    (resync[i]),
      .voted_i     (voted),
      .fault_inj_i (fault_inj_i[i]),
      .state_o     (core_state[i])
    );
  end

  tmr_voter u_voter (
    .state_i   (core_state),
    .voted_o   (voted),
    .faulty_o  (faulty_o),
    .error_o   (tmr_error_o),
    .failure_o (tmr_failure_o)
  );

  fault_monitor u_monitor (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .faulty_i  (faulty_o),
    .resync_o  (resync),
    .err_cnt_o (err_cnt_o)
  );

  rsp_egress u_egress (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .issue_i      (issue),
    .voted_i      (voted),
    .rsp_credit_i (rsp_credit_i),
    .issue_ok_o   (issue_ok),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/tb_checker.sv ====
// Reference model and response checks
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic                                                cmd_valid_i,
  input  tmr_pkg::cmd_t                                       cmd_i,
  input  logic                                                cmd_credit_i,
  input  logic                                                rsp_credit_i,
  input  logic                                                rsp_valid_i,
  input  tmr_pkg::rsp_t                                       rsp_i,
  input  logic [tmr_pkg::NumCores-1:0]                        fault_inj_i,
  input  logic                                                tmr_error_i,
  input  logic                                                tmr_failure_i,
  input  logic [tmr_pkg::NumCores-1:0]                        faulty_i,
  input  logic [tmr_pkg::NumCores-1:0][tmr_pkg::CntWidth-1:0] err_cnt_i,
  input  logic                                                drain_done_i,
  input  int                                                  expected_cmds_i,
  output int                                                  errors_o,
  output int                                                  rsp_count_o,
  output logic                                                final_done_o
);

  localparam int CntMax = (1 << tmr_pkg::CntWidth) - 1;

  tmr_pkg::cmd_t                 cmd_q[$];
  logic [tmr_pkg::DataWidth-1:0] ref_acc;
  logic [tmr_pkg::NumCores-1:0]  inj_prev;  // Faults applied at the coming edge
  int                            fault_cycles[tmr_pkg::NumCores];
  int                            cmds_seen;
  int                            credit_pulses;
  int                            rsp_credits_seen;
  int                            rsp_count;
  int                            errors;

  assign errors_o    = errors;
  assign rsp_count_o = rsp_count;

  function automatic logic [tmr_pkg::DataWidth-1:0] apply_cmd(
    input logic [tmr_pkg::DataWidth-1:0] acc,
    input tmr_pkg::cmd_t                 c
  );
    case (c.op)
      tmr_pkg::OP_LOAD: return c.operand;
      tmr_pkg::OP_ADD:  return acc + c.operand;
      tmr_pkg::OP_XOR:  return acc ^ c.operand;
      default:          return acc << (c.operand % tmr_pkg::DataWidth);
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("CHECK FAILED time %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR at time %0t: %s", $time, msg);
  endtask

  task automatic check_response();
    tmr_pkg::cmd_t c;
    rsp_count++;
    if (rsp_count > rsp_credits_seen + tmr_pkg::NumCredits) begin
      report_problem("Response sent beyond the credits returned");
    end
    if (cmd_q.size() == 0) begin
      report_problem("Response arrived with no outstanding command");
    end else begin
      c = cmd_q.pop_front();
      ref_acc = apply_cmd(ref_acc, c);
      if (rsp_i.acc !== ref_acc) begin
        report_mismatch("rsp_o.acc", 32'(ref_acc), 32'(rsp_i.acc));
      end
      if (rsp_i.op !== c.op) begin
        report_mismatch("rsp_o.op", 32'(c.op), 32'(rsp_i.op));
      end
    end
  endtask

  task automatic final_checks();
    int exp_cnt;
    if (cmd_q.size() != 0) begin
      report_problem($sformatf("%0d commands never produced a response", cmd_q.size()));
    end
    if (cmds_seen != expected_cmds_i) begin
      report_mismatch("commands sent", 32'(expected_cmds_i), 32'(cmds_seen));
    end
    if (credit_pulses != cmds_seen) begin
      report_mismatch("cmd_credit_o pulses", 32'(cmds_seen), 32'(credit_pulses));
    end
    if (rsp_count != expected_cmds_i) begin
      report_mismatch("rsp_valid_o count", 32'(expected_cmds_i), 32'(rsp_count));
    end
    for (int k = 0; k < tmr_pkg::NumCores; k++) begin
      exp_cnt = (fault_cycles[k] > CntMax) ? CntMax : fault_cycles[k];  // Saturating
      if (int'(err_cnt_i[k]) != exp_cnt) begin
        report_mismatch($sformatf("err_cnt_o[%0d]", k), 32'(exp_cnt), 32'(err_cnt_i[k]));
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      cmd_q.delete();
      ref_acc          = '0;
      inj_prev         = '0;
      cmds_seen        = 0;
      credit_pulses    = 0;
      rsp_credits_seen = 0;
      rsp_count        = 0;
      errors           = 0;
      final_done_o     = 1'b0;
      for (int k = 0; k < tmr_pkg::NumCores; k++) begin
        fault_cycles[k] = 0;
      end
    end else begin
      if (cmd_valid_i) begin
        cmd_q.push_back(cmd_i);
        cmds_seen++;
      end
      if (cmd_credit_i) begin
        credit_pulses++;
      end
      if (rsp_credit_i) begin
        rsp_credits_seen++;
      end
      if (rsp_valid_i) begin
        check_response();
      end
      // A fault shows up one cycle after injection, the resync clears it
      if (faulty_i !== inj_prev) begin
        report_mismatch("faulty_o", 32'(inj_prev), 32'(faulty_i));
      end
      if (tmr_error_i !== (|inj_prev)) begin
        report_mismatch("tmr_error_o", 32'(|inj_prev), 32'(tmr_error_i));
      end
      if (tmr_failure_i !== 1'b0) begin
        report_problem("tmr_failure_o raised under a single fault");
      end
      for (int k = 0; k < tmr_pkg::NumCores; k++) begin
        if (faulty_i[k]) begin
          fault_cycles[k]++;
        end
      end
      inj_prev = fault_inj_i;
      if (drain_done_i && !final_done_o) begin
        final_checks();
        final_done_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tmr_core_wrap_assert.sv ====
// TMR protocol assertions
`timescale 1ns/1ps
`default_nettype none

module tmr_core_wrap_assert (
  input logic                          clk_i,
  input logic                          arst_n_i,
  input logic                          cmd_valid_i,
  input logic                          issue_i,
  input logic                          rsp_valid_i,
  input logic [tmr_pkg::FillWidth-1:0] credit_cnt_i,
  input logic [tmr_pkg::FillWidth-1:0] fill_i,
  input logic [tmr_pkg::NumCores-1:0]  fault_inj_i,
  input logic [tmr_pkg::NumCores-1:0]  faulty_i,
  input logic                          error_i,
  input logic                          failure_i
);

  int unsigned fail_count = 0;

  // Each response comes from a credited issue two edges back
  a_rsp_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_i |-> $past(issue_i, 2))
    else begin
      $error("Response without a command issued two cycles earlier");
      fail_count++;
    end

  a_credit_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_cnt_i <= tmr_pkg::FillWidth'(tmr_pkg::NumCredits))
    else begin
      $error("Response credit count above its initial value");
      fail_count++;
    end

  a_cmd_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_i |-> (fill_i != tmr_pkg::FillWidth'(tmr_pkg::NumCredits)))
    else begin
      $error("Command arrived while the queue was full");
      fail_count++;
    end

  // Resync clears the disagreement unless the replica is hit again
  a_resync: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (faulty_i != '0) |=> ((faulty_i & $past(faulty_i) & ~$past(fault_inj_i)) == '0))
    else begin
      $error("Faulty replica not resynchronised at the next edge");
      fail_count++;
    end

  a_failure: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    error_i |-> ($onehot(faulty_i) && !failure_i))
    else begin
      $error("Error flag without exactly one faulty replica");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== sim/tb_tmr_core_wrap.sv ====
// TMR accumulator testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_tmr_core_wrap;

  localparam int          NumCmds       = 600;
  localparam int          TimeoutCycles = NumCmds * 8 + 3;  // Worst case per command plus reset
  localparam logic [31:0] Seed          = 32'd40834;

  logic                                                clk;
  logic                                                arst_n;
  logic                                                cmd_valid;
  tmr_pkg::cmd_t                                       cmd;
  logic                                                cmd_credit;
  logic                                                rsp_credit;
  logic                                                rsp_valid;
  tmr_pkg::rsp_t                                       rsp;
  logic [tmr_pkg::NumCores-1:0]                        fault_inj;
  logic                                                tmr_error;
  logic                                                tmr_failure;
  logic [tmr_pkg::NumCores-1:0]                        faulty;
  logic [tmr_pkg::NumCores-1:0][tmr_pkg::CntWidth-1:0] err_cnt;
  logic                                                drain_done;
  logic                                                final_done;
  int                                                  errors;
  int                                                  rsp_count;
  int unsigned                                         asrt_errors;

  logic [31:0] rng_state;
  int          sent;
  int          cmd_credits;
  int          rsp_pending;  // Responses not yet credited back
  int          rsp_rcvd;
  int          hold;
  int          cycles;
  logic        inject_en;

  tb_clkgen u_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  tmr_core_wrap u_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .cmd_credit_o  (cmd_credit),
    .rsp_credit_i  (rsp_credit),
    .rsp_valid_o   (rsp_valid),
    .rsp_o         (rsp),
    .fault_inj_i   (fault_inj),
    .tmr_error_o   (tmr_error),
    .tmr_failure_o (tmr_failure),
    .faulty_o      (faulty),
    .err_cnt_o     (err_cnt)
  );

  tb_checker u_checker (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .cmd_valid_i     (cmd_valid),
    .cmd_i           (cmd),
    .cmd_credit_i    (cmd_credit),
    .rsp_credit_i    (rsp_credit),
    .rsp_valid_i     (rsp_valid),
    .rsp_i           (rsp),
    .fault_inj_i     (fault_inj),
    .tmr_error_i     (tmr_error),
    .tmr_failure_i   (tmr_failure),
    .faulty_i        (faulty),
    .err_cnt_i       (err_cnt),
    .drain_done_i    (drain_done),
    .expected_cmds_i (NumCmds),
    .errors_o        (errors),
    .rsp_count_o     (rsp_count),
    .final_done_o    (final_done)
  );

  bind tmr_core_wrap tmr_core_wrap_assert u_assert (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_valid_i  (cmd_valid_i),
    .issue_i      (issue),
    .rsp_valid_i  (rsp_valid_o),
    .credit_cnt_i (u_egress.credit_q),
    .fill_i       (u_ingress.fill_q),
    .fault_inj_i  (fault_inj_i),
    .faulty_i     (faulty_o),
    .error_i      (tmr_error_o),
    .failure_i    (tmr_failure_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic drive_cycle();
    logic [31:0] r1;
    logic [31:0] r2;
    rng_state = xorshift32(rng_state);
    r1 = rng_state;
    rng_state = xorshift32(rng_state);
    r2 = rng_state;
    cmd_valid  = 1'b0;
    rsp_credit = 1'b0;
    fault_inj  = '0;
    if (sent < NumCmds && cmd_credits > 0 && r1[1:0] != 2'b00) begin
      cmd_valid   = 1'b1;
      cmd.op      = tmr_pkg::op_e'(r1[3:2]);
      cmd.operand = r1[19:4];
      cmd_credits--;
      sent++;
    end
    if (hold > 0) begin
      hold--;  // Response credits withheld
    end else if (r2[11:6] == 6'd0) begin
      hold = 8 + int'(r2[15:12]);
    end else if (rsp_pending > 0 && r2[1:0] != 2'b00) begin
      rsp_credit = 1'b1;
      rsp_pending--;
    end
    // Rare single fault, never two replicas in one cycle
    if (inject_en && r2[24:20] == 5'd0 && r2[26:25] != 2'b11) begin
      fault_inj[r2[26:25]] = 1'b1;
    end
  endtask

  task automatic sample_outputs();
    if (cmd_credit) begin
      cmd_credits++;
    end
    if (rsp_valid) begin
      rsp_pending++;
      rsp_rcvd++;
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d responses received",
             cycles, rsp_rcvd, NumCmds);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    cmd_valid   = 1'b0;
    cmd         = '0;
    rsp_credit  = 1'b0;
    fault_inj   = '0;
    drain_done  = 1'b0;
    rng_state   = Seed;
    sent        = 0;
    cmd_credits = tmr_pkg::NumCredits;
    rsp_pending = 0;
    rsp_rcvd    = 0;
    hold        = 0;
    inject_en   = 1'b1;
    @(posedge arst_n);
    do begin
      @(posedge clk);
      #1;
      drive_cycle();
      @(negedge clk);
      sample_outputs();
    end while (rsp_rcvd < NumCmds);
    inject_en = 1'b0;
    repeat (4) begin  // Let the last resync and counter update settle
      @(posedge clk);
      #1;
      drive_cycle();
    end
    drain_done = 1'b1;
    wait (final_done);
    asrt_errors = u_dut.u_assert.fail_count;
    $display("Commands %0d, responses %0d, check errors %0d, assertion errors %0d",
             sent, rsp_count, errors, asrt_errors);
    if (errors == 0 && asrt_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tmr_core_wrap.f ====
src/tmr_pkg.sv
src/cmd_ingress.sv
src/acc_core.sv
src/tmr_voter.sv
src/fault_monitor.sv
src/rsp_egress.sv
src/tmr_core_wrap.sv
sim/tb_clkgen.sv
sim/tb_checker.sv
sim/tmr_core_wrap_assert.sv
sim/tb_tmr_core_wrap.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_tmr_core_wrap
SRCS := $(shell cat tmr_core_wrap.f)

.PHONY: all run clean

all: run

$(SIM): tmr_core_wrap.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_tmr_core_wrap -f tmr_core_wrap.f

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -qx "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
